//--- hw/color_gen_pkg.sv
`default_nettype none

package color_gen_pkg;

    // one colour channel or intensity value
    typedef logic [7:0] channel_t;
    // full multiplier product
    typedef logic [15:0] product_t;
    // command code on the mode input
    typedef logic [7:0] mode_t;
    // hue ramp segment number
    typedef logic [2:0] seg_t;

    // command codes
    localparam mode_t MODE_PASSTHROUGH = 8'h21;
    localparam mode_t MODE_GENERATE = 8'hA4;

    // hue ramp shape
    localparam channel_t HUE_STEP = 8'd7;
    localparam channel_t HUE_SEGMENT_LEN = 8'd42;
    localparam int HUE_SEGMENTS = 6;
    localparam channel_t CHANNEL_MAX = 8'hFF;

    // shift-add iterations, one per multiplier bit
    localparam int MULT_STEPS = 8;
    typedef logic [$clog2(MULT_STEPS)-1:0] step_t;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_WAIT,
        CTRL_MIX
    } ctrl_state_t;

    typedef enum logic {
        RAMP_IDLE,
        RAMP_RUN
    } ramp_state_t;

    typedef enum logic [1:0] {
        MIX_IDLE,
        MIX_RED,
        MIX_GREEN,
        MIX_BLUE
    } mix_state_t;

endpackage

`default_nettype wire

//--- hw/shift_add_mult.sv
`default_nettype none

module shift_add_mult
    import color_gen_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  channel_t multiplicand,
    input  channel_t multiplier,
    output channel_t product_high,
    output logic     done
);

    logic     busy;
    step_t    step_cnt;
    product_t acc;
    product_t acc_next;
    product_t mcand_sh;
    channel_t mplier_sh;

    // add shifted multiplicand when current multiplier bit is set
    assign acc_next = mplier_sh[0] ? acc + mcand_sh : acc;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            busy <= 1'b0;
            done <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            // start while busy is dropped
            if (!busy && start)
                busy <= 1'b1;
            else if (busy && step_cnt == step_t'(MULT_STEPS - 1))
            begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!busy && start)
        begin
            // bit 0 is handled on the start edge itself
            acc <= multiplier[0] ? product_t'(multiplicand) : '0;
            mcand_sh <= product_t'(multiplicand) << 1;
            mplier_sh <= multiplier >> 1;
            step_cnt <= step_t'(1);
        end
        else if (busy)
        begin
            acc <= acc_next;
            mcand_sh <= mcand_sh << 1;
            mplier_sh <= mplier_sh >> 1;
            step_cnt <= step_cnt + 1'b1;
            // last bit, keep only the upper byte
            if (step_cnt == step_t'(MULT_STEPS - 1))
                product_high <= acc_next[15:8];
        end
    end

endmodule

`default_nettype wire

//--- hw/hue_ramp.sv
`default_nettype none

module hue_ramp
    import color_gen_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  channel_t color_idx,
    output channel_t red,
    output channel_t green,
    output channel_t blue,
    output logic     done
);

    ramp_state_t state;
    channel_t    count;
    channel_t    target;
    channel_t    pos;
    seg_t        seg;
    logic        seg_wrap;

    // rising channel, clamps at full scale
    function automatic channel_t rise(input channel_t value);
        if (value > CHANNEL_MAX - HUE_STEP)
            return CHANNEL_MAX;
        return value + HUE_STEP;
    endfunction

    // falling channel, clamps at zero
    function automatic channel_t fall(input channel_t value);
        if (value < HUE_STEP)
            return '0;
        return value - HUE_STEP;
    endfunction

    // end of a segment, last one runs on to the top of the index range
    assign seg_wrap = (pos == HUE_SEGMENT_LEN - 8'd1) && (seg != seg_t'(HUE_SEGMENTS - 1));

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state <= RAMP_IDLE;
            done <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                RAMP_IDLE:
                begin
                    // index 0 is the initial colour, no stepping
                    if (start && color_idx == '0)
                        done <= 1'b1;
                    else if (start)
                        state <= RAMP_RUN;
                end
                RAMP_RUN:
                begin
                    // this step lands on the index
                    if (count + 8'd1 == target)
                    begin
                        done <= 1'b1;
                        state <= RAMP_IDLE;
                    end
                end
                default:
                    state <= RAMP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == RAMP_IDLE && start)
        begin
            count <= '0;
            target <= color_idx;
            seg <= '0;
            pos <= '0;
            red <= CHANNEL_MAX;
            green <= '0;
            blue <= '0;
        end
        else if (state == RAMP_RUN)
        begin
            count <= count + 8'd1;
            if (seg_wrap)
            begin
                seg <= seg + 3'd1;
                pos <= '0;
                // fixed pair of the next segment, moving one holds
                case (seg + 3'd1)
                    3'd1:
                    begin
                        green <= '0;
                        blue <= CHANNEL_MAX;
                    end
                    3'd2:
                    begin
                        red <= '0;
                        blue <= CHANNEL_MAX;
                    end
                    3'd3:
                    begin
                        red <= '0;
                        green <= CHANNEL_MAX;
                    end
                    3'd4:
                    begin
                        green <= CHANNEL_MAX;
                        blue <= '0;
                    end
                    default:
                    begin
                        red <= CHANNEL_MAX;
                        blue <= '0;
                    end
                endcase
            end
            else
            begin
                pos <= pos + 8'd1;
                // moving channel of the current segment
                case (seg)
                    3'd0: blue <= rise(blue);
                    3'd1: red <= fall(red);
                    3'd2: green <= rise(green);
                    3'd3: blue <= fall(blue);
                    3'd4: red <= rise(red);
                    default: green <= fall(green);
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/white_scaler.sv
`default_nettype none

module white_scaler
    import color_gen_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  channel_t lint,
    input  channel_t white_in,
    output channel_t white_scaled,
    output logic     done
);

    logic     busy;
    logic     mult_start;
    logic     mult_done;
    channel_t mult_high;

    // only launch from idle
    assign mult_start = start && !busy;

    shift_add_mult mult_inst (
        .clk          (clk),
        .reset        (reset),
        .start        (mult_start),
        .multiplicand (lint),
        .multiplier   (white_in),
        .product_high (mult_high),
        .done         (mult_done)
    );

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            busy <= 1'b0;
            done <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (mult_start)
                busy <= 1'b1;
            else if (mult_done)
            begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // result held until the next frame
    always_ff @(posedge clk)
    begin
        if (mult_done)
            white_scaled <= mult_high;
    end

endmodule

`default_nettype wire

//--- hw/color_mixer.sv
`default_nettype none

module color_mixer
    import color_gen_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  logic     pass_load,
    input  channel_t lint,
    input  channel_t white_level,
    input  channel_t hue_red,
    input  channel_t hue_green,
    input  channel_t hue_blue,
    input  channel_t white_scaled,
    input  channel_t red_in,
    input  channel_t green_in,
    input  channel_t blue_in,
    input  channel_t white_in,
    output channel_t red_out,
    output channel_t green_out,
    output channel_t blue_out,
    output channel_t white_out,
    output logic     done
);

    mix_state_t state;
    logic       mult_go;
    logic       mult_done;
    channel_t   mult_high;
    channel_t   mult_operand;
    channel_t   sum_red;
    channel_t   sum_green;
    channel_t   sum_blue;
    channel_t   scaled_red;
    channel_t   scaled_green;

    // 9-bit sum, carry out means clamp
    function automatic channel_t sat_add(input channel_t a, input channel_t b);
        logic [8:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[8] ? CHANNEL_MAX : sum[7:0];
    endfunction

    // one shared multiplier, operand follows the channel in flight
    always_comb
    begin
        case (state)
            MIX_GREEN: mult_operand = sum_green;
            MIX_BLUE: mult_operand = sum_blue;
            default: mult_operand = sum_red;
        endcase
    end

    shift_add_mult mult_inst (
        .clk          (clk),
        .reset        (reset),
        .start        (mult_go),
        .multiplicand (lint),
        .multiplier   (mult_operand),
        .product_high (mult_high),
        .done         (mult_done)
    );

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state <= MIX_IDLE;
            mult_go <= 1'b0;
            done <= 1'b0;
            red_out <= '0;
            green_out <= '0;
            blue_out <= '0;
            white_out <= '0;
        end
        else
        begin
            mult_go <= 1'b0;
            done <= 1'b0;
            case (state)
                MIX_IDLE:
                begin
                    if (start)
                    begin
                        state <= MIX_RED;
                        mult_go <= 1'b1;
                    end
                    else if (pass_load)
                    begin
                        // raw copy, no scaling
                        red_out <= red_in;
                        green_out <= green_in;
                        blue_out <= blue_in;
                        white_out <= white_in;
                    end
                end
                MIX_RED:
                begin
                    if (mult_done)
                    begin
                        state <= MIX_GREEN;
                        mult_go <= 1'b1;
                    end
                end
                MIX_GREEN:
                begin
                    if (mult_done)
                    begin
                        state <= MIX_BLUE;
                        mult_go <= 1'b1;
                    end
                end
                MIX_BLUE:
                begin
                    // blue is taken straight off the multiplier
                    if (mult_done)
                    begin
                        red_out <= scaled_red;
                        green_out <= scaled_green;
                        blue_out <= mult_high;
                        white_out <= white_scaled;
                        done <= 1'b1;
                        state <= MIX_IDLE;
                    end
                end
                default:
                    state <= MIX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        // white added on the start edge
        if (state == MIX_IDLE && start)
        begin
            sum_red <= sat_add(hue_red, white_level);
            sum_green <= sat_add(hue_green, white_level);
            sum_blue <= sat_add(hue_blue, white_level);
        end
        if (mult_done && state == MIX_RED)
            scaled_red <= mult_high;
        if (mult_done && state == MIX_GREEN)
            scaled_green <= mult_high;
    end

endmodule

`default_nettype wire

//--- hw/frame_ctrl.sv
`default_nettype none

module frame_ctrl
    import color_gen_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  mode_t    mode,
    input  channel_t lint,
    input  channel_t color_idx,
    input  channel_t white_in,
    output channel_t frame_lint,
    output channel_t frame_idx,
    output channel_t frame_white,
    output logic     ramp_start,
    output logic     white_start,
    output logic     mix_start,
    output logic     pass_load,
    input  logic     ramp_done,
    input  logic     white_done,
    input  logic     mix_done,
    output logic     frame_done
);

    ctrl_state_t state;
    mode_t       mode_q;
    logic        ramp_seen;
    logic        white_seen;
    logic        both_done;

    // done pulses may come in either order
    assign both_done = (ramp_seen || ramp_done) && (white_seen || white_done);

    // passthrough load every idle cycle while the mode holds
    assign pass_load = (state == CTRL_IDLE) && (mode_q == MODE_PASSTHROUGH);

    // end of frame is the mixer's done
    assign frame_done = mix_done;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state <= CTRL_IDLE;
            mode_q <= '0;
            ramp_start <= 1'b0;
            white_start <= 1'b0;
            mix_start <= 1'b0;
            ramp_seen <= 1'b0;
            white_seen <= 1'b0;
        end
        else
        begin
            mode_q <= mode;
            ramp_start <= 1'b0;
            white_start <= 1'b0;
            mix_start <= 1'b0;
            case (state)
                CTRL_IDLE:
                begin
                    // unknown codes leave the FSM idle
                    if (mode_q == MODE_GENERATE)
                    begin
                        ramp_start <= 1'b1;
                        white_start <= 1'b1;
                        ramp_seen <= 1'b0;
                        white_seen <= 1'b0;
                        state <= CTRL_WAIT;
                    end
                end
                CTRL_WAIT:
                begin
                    ramp_seen <= ramp_seen || ramp_done;
                    white_seen <= white_seen || white_done;
                    if (both_done)
                    begin
                        mix_start <= 1'b1;
                        state <= CTRL_MIX;
                    end
                end
                CTRL_MIX:
                begin
                    if (mix_done)
                        state <= CTRL_IDLE;
                end
                default:
                    state <= CTRL_IDLE;
            endcase
        end
    end

    // frame inputs frozen for the whole frame
    always_ff @(posedge clk)
    begin
        if (state == CTRL_IDLE && mode_q == MODE_GENERATE)
        begin
            frame_lint <= lint;
            frame_idx <= color_idx;
            frame_white <= white_in;
        end
    end

endmodule

`default_nettype wire

//--- hw/color_gen_top.sv
`default_nettype none

module color_gen_top
    import color_gen_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  mode_t    mode,
    input  channel_t lint,
    input  channel_t color_idx,
    input  channel_t white_in,
    input  channel_t red_in,
    input  channel_t green_in,
    input  channel_t blue_in,
    output channel_t red_out,
    output channel_t green_out,
    output channel_t blue_out,
    output channel_t white_out,
    output logic     frame_done
);

    // frame registers
    channel_t frame_lint;
    channel_t frame_idx;
    channel_t frame_white;

    // unit handshakes
    logic ramp_start;
    logic white_start;
    logic mix_start;
    logic pass_load;
    logic ramp_done;
    logic white_done;
    logic mix_done;

    // unit results
    channel_t hue_red;
    channel_t hue_green;
    channel_t hue_blue;
    channel_t white_scaled;

    frame_ctrl frame_ctrl_inst (
        .clk         (clk),
        .reset       (reset),
        .mode        (mode),
        .lint        (lint),
        .color_idx   (color_idx),
        .white_in    (white_in),
        .frame_lint  (frame_lint),
        .frame_idx   (frame_idx),
        .frame_white (frame_white),
        .ramp_start  (ramp_start),
        .white_start (white_start),
        .mix_start   (mix_start),
        .pass_load   (pass_load),
        .ramp_done   (ramp_done),
        .white_done  (white_done),
        .mix_done    (mix_done),
        .frame_done  (frame_done)
    );

    // ramp and white scaling run side by side
    hue_ramp hue_ramp_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (ramp_start),
        .color_idx (frame_idx),
        .red       (hue_red),
        .green     (hue_green),
        .blue      (hue_blue),
        .done      (ramp_done)
    );

    white_scaler white_scaler_inst (
        .clk          (clk),
        .reset        (reset),
        .start        (white_start),
        .lint         (frame_lint),
        .white_in     (frame_white),
        .white_scaled (white_scaled),
        .done         (white_done)
    );

    color_mixer color_mixer_inst (
        .clk          (clk),
        .reset        (reset),
        .start        (mix_start),
        .pass_load    (pass_load),
        .lint         (frame_lint),
        .white_level  (frame_white),
        .hue_red      (hue_red),
        .hue_green    (hue_green),
        .hue_blue     (hue_blue),
        .white_scaled (white_scaled),
        .red_in       (red_in),
        .green_in     (green_in),
        .blue_in      (blue_in),
        .white_in     (white_in),
        .red_out      (red_out),
        .green_out    (green_out),
        .blue_out     (blue_out),
        .white_out    (white_out),
        .done         (mix_done)
    );

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    // 10 ns period, starts low
    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk;
    end

endmodule

`default_nettype wire

//--- tests/tb_color_gen.sv
`default_nettype none

module tb_color_gen
    import color_gen_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 8;
    localparam int RANDOM_FRAMES = 50;
    localparam int CYCLES_PER_FRAME = 1000;
    // ramp points, random frames, saturation frames, then idle, passthrough and unknown phases
    localparam int TEST_FRAMES = 6 + RANDOM_FRAMES + 8 + 3;
    localparam logic [31:0] RANDOM_SEED = 32'hfa192053;

    logic     clk;
    logic     reset;
    mode_t    mode;
    channel_t lint;
    channel_t color_idx;
    channel_t white_in;
    channel_t red_in;
    channel_t green_in;
    channel_t blue_in;
    channel_t red_out;
    channel_t green_out;
    channel_t blue_out;
    channel_t white_out;
    logic     frame_done;

    // expected {red, green, blue, white} for each frame in flight
    logic [31:0] expected_q [$];
    logic [31:0] checked_rgbw;
    // reference result of the most recent generate frame
    logic [31:0] last_rgbw;

    tb_clock clock_inst (
        .clk (clk)
    );

    color_gen_top color_gen_top_inst (
        .clk        (clk),
        .reset      (reset),
        .mode       (mode),
        .lint       (lint),
        .color_idx  (color_idx),
        .white_in   (white_in),
        .red_in     (red_in),
        .green_in   (green_in),
        .blue_in    (blue_in),
        .red_out    (red_out),
        .green_out  (green_out),
        .blue_out   (blue_out),
        .white_out  (white_out),
        .frame_done (frame_done)
    );

    function automatic int clamp_byte(input int value);
        if (value < 0)
            return 0;
        if (value > 255)
            return 255;
        return value;
    endfunction

    // upper byte of the 16-bit product
    function automatic channel_t upper_byte(input channel_t level, input int value);
        return channel_t'((int'(level) * value) >> 8);
    endfunction

    function automatic logic [31:0] reference_rgbw(input channel_t idx, input channel_t level,
                                                   input channel_t white);
        int seg;
        int t;
        int hue [3];
        int mixed [3];
        seg = int'(idx) / 42;
        // last segment runs on to index 255
        if (seg > 5)
            seg = 5;
        t = int'(idx) - 42 * seg;
        // hue order is red, green, blue
        case (seg)
            0: hue = '{255, 0, clamp_byte(7 * t)};
            1: hue = '{clamp_byte(255 - 7 * t), 0, 255};
            2: hue = '{0, clamp_byte(7 * t), 255};
            3: hue = '{0, 255, clamp_byte(255 - 7 * t)};
            4: hue = '{clamp_byte(7 * t), 255, 0};
            default: hue = '{255, clamp_byte(255 - 7 * t), 0};
        endcase
        for (int i = 0; i < 3; i++)
            mixed[i] = clamp_byte(hue[i] + int'(white));
        return {upper_byte(level, mixed[0]), upper_byte(level, mixed[1]),
                upper_byte(level, mixed[2]), upper_byte(level, int'(white))};
    endfunction

    function automatic channel_t random_byte();
        return channel_t'($urandom_range(255, 0));
    endfunction

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_channel(input string name, input channel_t expected,
                                 input channel_t actual);
        assert (actual === expected)
        else
        begin
            $display("[FAIL] %0t ns %s expected %0d actual %0d", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_outputs(input logic [31:0] rgbw);
        check_channel("red_out", rgbw[31:24], red_out);
        check_channel("green_out", rgbw[23:16], green_out);
        check_channel("blue_out", rgbw[15:8], blue_out);
        check_channel("white_out", rgbw[7:0], white_out);
    endtask

    // stimulus goes out 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // returns in the cycle where frame_done is high
    task automatic run_frame(input channel_t idx, input channel_t level, input channel_t white);
        color_idx = idx;
        lint = level;
        white_in = white;
        mode = MODE_GENERATE;
        last_rgbw = reference_rgbw(idx, level, white);
        expected_q.push_back(last_rgbw);
        do
            next_cycle();
        while (frame_done !== 1'b1);
    endtask

    task automatic idle_after_reset();
        for (int n = 0; n < 20; n++)
        begin
            red_in = random_byte();
            green_in = random_byte();
            blue_in = random_byte();
            next_cycle();
            check_outputs(32'h0);
        end
    endtask

    task automatic passthrough();
        channel_t pixel [4];
        mode = MODE_PASSTHROUGH;
        for (int n = 0; n < 10; n++)
        begin
            foreach (pixel[i])
                pixel[i] = random_byte();
            red_in = pixel[0];
            green_in = pixel[1];
            blue_in = pixel[2];
            white_in = pixel[3];
            // mode register and then the output load
            repeat (2) next_cycle();
            check_outputs({pixel[0], pixel[1], pixel[2], pixel[3]});
        end
    endtask

    task automatic ramp_points();
        channel_t points [6];
        points = '{8'd0, 8'd41, 8'd42, 8'd126, 8'd200, 8'd255};
        foreach (points[i])
            run_frame(points[i], 8'd255, 8'd0);
    endtask

    task automatic random_frames();
        for (int n = 0; n < RANDOM_FRAMES; n++)
            run_frame(random_byte(), random_byte(), random_byte());
    endtask

    task automatic white_saturation();
        channel_t full_scale;
        channel_t points [4];
        full_scale = channel_t'((255 * 255) >> 8);
        points = '{8'd0, 8'd30, 8'd100, 8'd220};
        foreach (points[i])
            run_frame(points[i], 8'd255, 8'd200);
        // white at full scale clamps every colour sum
        foreach (points[i])
        begin
            run_frame(points[i], 8'd255, 8'd255);
            check_channel("red_out", full_scale, red_out);
            check_channel("green_out", full_scale, green_out);
            check_channel("blue_out", full_scale, blue_out);
        end
    endtask

    // called in the frame_done cycle, so no new frame gets started
    task automatic unknown_mode();
        logic [31:0] held;
        mode = 8'h00;
        // outputs of the last generate frame stay in place
        held = last_rgbw;
        for (int n = 0; n < 40; n++)
        begin
            if (n == 20)
                mode = 8'h5A;
            color_idx = random_byte();
            lint = random_byte();
            white_in = random_byte();
            red_in = random_byte();
            next_cycle();
            check_outputs(held);
        end
    endtask

    // every frame_done must match the oldest outstanding frame
    initial
    begin
        forever
        begin
            @(negedge clk);
            if (frame_done === 1'b1)
            begin
                assert (expected_q.size() != 0)
                else
                begin
                    $display("frame_done pulsed at %0t ns with no frame started", $time);
                    abort_run();
                end
                checked_rgbw = expected_q.pop_front();
                check_outputs(checked_rgbw);
            end
        end
    end

    initial
    begin
        #(TEST_FRAMES * CYCLES_PER_FRAME * CLK_PERIOD);
        $display("timeout: run still busy after %0d cycles", TEST_FRAMES * CYCLES_PER_FRAME);
        abort_run();
    end

    initial
    begin
        void'($urandom(RANDOM_SEED));
        reset = 1'b0;
        mode = '0;
        lint = '0;
        color_idx = '0;
        white_in = '0;
        red_in = '0;
        green_in = '0;
        blue_in = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b1;

        idle_after_reset();
        passthrough();
        ramp_points();
        random_frames();
        white_saturation();
        unknown_mode();

        // checker pops on the falling edge
        next_cycle();
        if (expected_q.size() == 0)
        begin
            $display("TESTS PASSED");
            $finish;
        end
        else
        begin
            $display("%0d frames never signalled frame_done", expected_q.size());
            abort_run();
        end
    end

endmodule

`default_nettype wire

//--- compile.f
hw/color_gen_pkg.sv
hw/shift_add_mult.sv
hw/hue_ramp.sv
hw/white_scaler.sv
hw/color_mixer.sv
hw/frame_ctrl.sv
hw/color_gen_top.sv
tests/tb_clock.sv
tests/tb_color_gen.sv

//--- run.sh
#!/bin/sh
# build and run the colour generator testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_color_gen -f compile.f -o sim_color_gen

# the log decides the result, so a fatal stop must not end the script here
./obj_dir/sim_color_gen > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS PASSED" sim.log
then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
